/* common/codec_defines.svh */
`ifndef CODEC_DEFINES_SVH
`define CODEC_DEFINES_SVH

// Codec device on the I2C bus
`define CODEC_I2C_ADDR 7'h3B   // 7-bit address, write byte 0x76

// Init table
`define INIT_WORDS 29          // Control words in the table
`define INIT_GAP_CYCLES 64     // Idle cycles between words

// I2C bit timing
`define I2C_QTR_CYCLES 4       // Clock cycles per quarter SCL period

// Register bus
`define REG_AW 2               // Address width
`define REG_DW 32              // Data width

`endif

/* common/codecPkg.sv */
`include "codec_defines.svh"

package codecPkg;

  typedef logic [23:0] initWord_t;  // {regAddrHi, regAddrLo, data}
  typedef logic [4:0] wordIdx_t;    // Table index

  // Init sequencer
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_LOAD,   // Wait for ROM word
    SEQ_SEND,   // Hand one byte to the master
    SEQ_WAIT,   // Byte in flight
    SEQ_GAP,    // Pause before next word
    SEQ_RETRY,  // Pause before resending same word
    SEQ_DONE
  } seqState_e;

  // I2C byte master
  typedef enum logic [2:0] {
    I2C_IDLE,
    I2C_START,
    I2C_BIT,    // Eight data bits, MSB first
    I2C_ACK,    // Ninth bit from the slave
    I2C_NEXT,   // Holds SCL low until the next byte
    I2C_STOP
  } i2cState_e;

  // Register map
  typedef enum logic [`REG_AW-1:0] {
    REG_CTRL    = `REG_AW'(0),
    REG_STATUS  = `REG_AW'(1),
    REG_ERRCNT  = `REG_AW'(2),
    REG_WORDIDX = `REG_AW'(3)
  } regAddr_e;

endpackage

/* codecInit/codecInitRom.sv */
`timescale 1ns/1ps

module codecInitRom import codecPkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  wordIdx_t  idx_i,
  output initWord_t word_o   // One cycle after idx_i
);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      word_o <= '0;
    end else begin
      case (idx_i)
        5'd0:  word_o <= 24'h400003;  // Clock control
        5'd1:  word_o <= 24'h401500;  // Serial port 0
        5'd2:  word_o <= 24'h401600;  // Serial port 1
        5'd3:  word_o <= 24'h401700;  // Converter
        5'd4:  word_o <= 24'h40F800;  // Sample rate
        5'd5:  word_o <= 24'h401913;  // ADCs on
        5'd6:  word_o <= 24'h402A03;  // DACs on
        5'd7:  word_o <= 24'h402903;  // Playback power
        5'd8:  word_o <= 24'h40F201;  // Serial in to DACs
        5'd9:  word_o <= 24'h40F97F;  // Clock enable 0
        5'd10: word_o <= 24'h40FA03;  // Clock enable 1
        5'd11: word_o <= 24'h402003;  // Line out mixer L
        5'd12: word_o <= 24'h402200;  // Mono out mixer
        5'd13: word_o <= 24'h402109;  // Line out mixer R
        5'd14: word_o <= 24'h4025E6;  // Line out L, 0 dB
        5'd15: word_o <= 24'h4026E6;  // Line out R, 0 dB
        5'd16: word_o <= 24'h402700;  // Mono out
        5'd17: word_o <= 24'h4023E6;  // Headphone L
        5'd18: word_o <= 24'h4024E6;  // Headphone R
        5'd19: word_o <= 24'h400A01;  // Rec mixer L 0
        5'd20: word_o <= 24'h400B05;  // Rec mixer L 1
        5'd21: word_o <= 24'h400C01;  // Rec mixer R 0
        5'd22: word_o <= 24'h400D05;  // Rec mixer R 1
        5'd23: word_o <= 24'h401C21;  // Play mixer L 0
        5'd24: word_o <= 24'h401D00;  // Play mixer L 1
        5'd25: word_o <= 24'h401E41;  // Play mixer R 0
        5'd26: word_o <= 24'h401F00;  // Play mixer R 1
        5'd27: word_o <= 24'h40F301;  // ADCs to serial out
        5'd28: word_o <= 24'h40F400;  // Pin config
        default: word_o <= '0;
      endcase
    end
  end

endmodule

/* codecInit/codecInitSeq.sv */
`timescale 1ns/1ps
`include "codec_defines.svh"

module codecInitSeq import codecPkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  initWord_t  romWord_i,
  output wordIdx_t   romIdx_o,    // Also the reported word index
  output logic       byteStb_o,
  output logic [7:0] txByte_o,
  output logic       lastByte_o,
  input  logic       byteDone_i,
  input  logic       byteNak_i,
  output logic       busy_o,
  output logic       done_o,
  output logic       nakPulse_o   // One per failed attempt
);

  localparam int GapW = (`INIT_GAP_CYCLES > 1) ? $clog2(`INIT_GAP_CYCLES) : 1;
  localparam logic [GapW-1:0] GapLast = GapW'(`INIT_GAP_CYCLES - 1);
  localparam wordIdx_t IdxLast = wordIdx_t'(`INIT_WORDS - 1);

  seqState_e state;
  logic [1:0] bytePos;     // 0 addr hi, 1 addr lo, 2 data
  logic [GapW-1:0] gapCnt;
  logic [7:0] byteSel;

  always_comb begin
    case (bytePos)
      2'd0:    byteSel = romWord_i[23:16];
      2'd1:    byteSel = romWord_i[15:8];
      default: byteSel = romWord_i[7:0];
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state      <= SEQ_IDLE;
      romIdx_o   <= '0;
      bytePos    <= '0;
      gapCnt     <= '0;
      byteStb_o  <= 1'b0;
      txByte_o   <= '0;
      lastByte_o <= 1'b0;
      busy_o     <= 1'b0;
      done_o     <= 1'b0;
      nakPulse_o <= 1'b0;
    end else begin
      byteStb_o  <= 1'b0;
      nakPulse_o <= 1'b0;
      case (state)
        SEQ_IDLE, SEQ_DONE: begin
          if (start_i) begin
            romIdx_o <= '0;
            bytePos  <= '0;
            busy_o   <= 1'b1;
            done_o   <= 1'b0;
            state    <= SEQ_LOAD;
          end
        end
        SEQ_LOAD: state <= SEQ_SEND;  // ROM word valid next cycle
        SEQ_SEND: begin
          byteStb_o  <= 1'b1;
          txByte_o   <= byteSel;
          lastByte_o <= (bytePos == 2'd2);
          state      <= SEQ_WAIT;
        end
        SEQ_WAIT: begin
          if (byteDone_i) begin
            gapCnt <= '0;
            if (byteNak_i) begin
              nakPulse_o <= 1'b1;
              bytePos    <= '0;  // Retry from first byte
              state      <= SEQ_RETRY;
            end else if (bytePos != 2'd2) begin
              bytePos <= bytePos + 2'd1;
              state   <= SEQ_SEND;
            end else if (romIdx_o == IdxLast) begin
              busy_o <= 1'b0;
              done_o <= 1'b1;
              state  <= SEQ_DONE;
            end else begin
              state <= SEQ_GAP;
            end
          end
        end
        SEQ_GAP, SEQ_RETRY: begin
          gapCnt <= gapCnt + 1'b1;
          if (gapCnt == GapLast) begin
            if (state == SEQ_GAP) romIdx_o <= romIdx_o + 1'b1;
            bytePos <= '0;
            state   <= SEQ_LOAD;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

/* i2cMaster/i2cMaster.sv */
`timescale 1ns/1ps
`include "codec_defines.svh"

module i2cMaster import codecPkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       byteStb_i,   // Send txByte_i, opens a transaction when idle
  input  logic [7:0] txByte_i,
  input  logic       lastByte_i,  // STOP after this byte
  output logic       byteDone_o,
  output logic       byteNak_o,   // Valid with byteDone_o
  input  logic       sda_i,
  input  logic       scl_i,
  output logic       sdaOe_o,     // High pulls SDA low
  output logic       sclOe_o      // High pulls SCL low
);

  localparam int QtrW = (`I2C_QTR_CYCLES > 1) ? $clog2(`I2C_QTR_CYCLES) : 1;
  localparam logic [QtrW-1:0] QtrLast = QtrW'(`I2C_QTR_CYCLES - 1);

  i2cState_e state;
  logic [QtrW-1:0] qCnt;  // Cycles within a quarter
  logic [1:0] qtr;        // Quarter within a bit
  logic [2:0] bitCnt;
  logic [7:0] shiftReg;
  logic [7:0] dataByte;   // Payload held while the address goes out
  logic lastFlag;
  logic addrPhase;        // Address byte in flight
  logic nakFlag;
  logic stretch;
  logic qtrEnd;

  assign stretch = ~sclOe_o & ~scl_i;  // SCL released but slave holds it low
  assign qtrEnd = (qCnt == QtrLast) && !stretch;

  // Line drive per state and quarter
  always_comb begin
    sdaOe_o = 1'b0;
    sclOe_o = 1'b0;
    case (state)
      I2C_START: begin
        sdaOe_o = (qtr >= 2'd2);  // SDA falls while SCL high
        sclOe_o = (qtr == 2'd3);
      end
      I2C_BIT: begin
        sdaOe_o = ~shiftReg[7];
        sclOe_o = (qtr == 2'd0) || (qtr == 2'd3);
      end
      I2C_ACK: begin
        sclOe_o = (qtr == 2'd0) || (qtr == 2'd3);  // SDA left to the slave
      end
      I2C_NEXT: begin
        sclOe_o = 1'b1;
      end
      I2C_STOP: begin
        sdaOe_o = (qtr <= 2'd1);  // SDA rises while SCL high
        sclOe_o = (qtr == 2'd0);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state      <= I2C_IDLE;
      qCnt       <= '0;
      qtr        <= '0;
      bitCnt     <= '0;
      shiftReg   <= '0;
      dataByte   <= '0;
      lastFlag   <= 1'b0;
      addrPhase  <= 1'b0;
      nakFlag    <= 1'b0;
      byteDone_o <= 1'b0;
      byteNak_o  <= 1'b0;
    end else begin
      byteDone_o <= 1'b0;
      byteNak_o  <= 1'b0;
      case (state)
        I2C_IDLE: begin
          qCnt <= '0;
          qtr  <= '0;
          if (byteStb_i) begin
            shiftReg  <= {`CODEC_I2C_ADDR, 1'b0};  // Write bit
            dataByte  <= txByte_i;
            lastFlag  <= lastByte_i;
            addrPhase <= 1'b1;
            nakFlag   <= 1'b0;
            state     <= I2C_START;
          end
        end
        I2C_NEXT: begin
          qCnt <= '0;
          qtr  <= '0;
          if (byteStb_i) begin
            shiftReg <= txByte_i;
            lastFlag <= lastByte_i;
            bitCnt   <= 3'd7;
            state    <= I2C_BIT;
          end
        end
        default: begin
          if (qtrEnd) begin
            qCnt <= '0;
            qtr  <= qtr + 2'd1;
          end else if (!stretch) begin
            qCnt <= qCnt + 1'b1;
          end
          if (qtrEnd && state == I2C_ACK && qtr == 2'd2) begin
            nakFlag <= sda_i;  // Sample mid SCL high
          end
          if (qtrEnd && qtr == 2'd3) begin
            case (state)
              I2C_START: begin
                bitCnt <= 3'd7;
                state  <= I2C_BIT;
              end
              I2C_BIT: begin
                shiftReg <= {shiftReg[6:0], 1'b0};
                bitCnt   <= bitCnt - 3'd1;
                if (bitCnt == 3'd0) state <= I2C_ACK;
              end
              I2C_ACK: begin
                if (nakFlag || (!addrPhase && lastFlag)) begin
                  state <= I2C_STOP;  // Done reported after STOP
                end else if (addrPhase) begin
                  addrPhase <= 1'b0;
                  shiftReg  <= dataByte;
                  bitCnt    <= 3'd7;
                  state     <= I2C_BIT;
                end else begin
                  byteDone_o <= 1'b1;
                  state      <= I2C_NEXT;
                end
              end
              I2C_STOP: begin
                byteDone_o <= 1'b1;
                byteNak_o  <= nakFlag;
                state      <= I2C_IDLE;
              end
              default: state <= I2C_IDLE;
            endcase
          end
        end
      endcase
    end
  end

endmodule

/* src/codecRegs.sv */
`timescale 1ns/1ps
`include "codec_defines.svh"

module codecRegs import codecPkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               regWe_i,
  input  logic               regRe_i,
  input  logic [`REG_AW-1:0] regAddr_i,
  input  logic [`REG_DW-1:0] regWdata_i,
  output logic [`REG_DW-1:0] regRdata_o,  // Valid the cycle after regRe_i
  input  logic               busy_i,
  input  logic               done_i,
  input  logic               nakPulse_i,
  input  wordIdx_t           wordIdx_i,
  output logic               startPulse_o
);

  localparam int DW = `REG_DW;

  regAddr_e addr;
  logic [7:0] errCnt;

  assign addr = regAddr_e'(regAddr_i);

  // Start strobe, dropped while a run is active
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      startPulse_o <= 1'b0;
    end else begin
      startPulse_o <= regWe_i && (addr == REG_CTRL) && regWdata_i[0] && !busy_i;
    end
  end

  // Saturating NAK counter
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      errCnt <= '0;
    end else if (startPulse_o) begin
      errCnt <= '0;
    end else if (nakPulse_i && errCnt != 8'hFF) begin
      errCnt <= errCnt + 8'd1;
    end
  end

  // Read port, holds last value between reads
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      regRdata_o <= '0;
    end else if (regRe_i) begin
      case (addr)
        REG_STATUS:  regRdata_o <= DW'({busy_i, done_i});
        REG_ERRCNT:  regRdata_o <= DW'(errCnt);
        REG_WORDIDX: regRdata_o <= DW'(wordIdx_i);
        default:     regRdata_o <= '0;  // CTRL start bit self-clears
      endcase
    end
  end

endmodule

/* src/audioCodecCtrl.sv */
`timescale 1ns/1ps
`include "codec_defines.svh"

module audioCodecCtrl import codecPkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               regWe_i,
  input  logic               regRe_i,
  input  logic [`REG_AW-1:0] regAddr_i,
  input  logic [`REG_DW-1:0] regWdata_i,
  output logic [`REG_DW-1:0] regRdata_o,
  input  logic               sda_i,
  input  logic               scl_i,
  output logic               sdaOe_o,
  output logic               sclOe_o
);

  logic startPulse;
  logic busy;
  logic done;
  logic nakPulse;
  wordIdx_t romIdx;   // Also the status word index
  initWord_t romWord;
  logic byteStb;
  logic [7:0] txByte;
  logic lastByte;
  logic byteDone;
  logic byteNak;

  codecRegs u_codecRegs (
    .clk_i, .rst_ni, .regWe_i, .regRe_i, .regAddr_i, .regWdata_i, .regRdata_o,
    .busy_i(busy), .done_i(done), .nakPulse_i(nakPulse), .wordIdx_i(romIdx),
    .startPulse_o(startPulse)
  );

  codecInitSeq u_codecInitSeq (
    .clk_i, .rst_ni, .start_i(startPulse), .romWord_i(romWord), .romIdx_o(romIdx),
    .byteStb_o(byteStb), .txByte_o(txByte), .lastByte_o(lastByte),
    .byteDone_i(byteDone), .byteNak_i(byteNak),
    .busy_o(busy), .done_o(done), .nakPulse_o(nakPulse)
  );

  codecInitRom u_codecInitRom (.clk_i, .rst_ni, .idx_i(romIdx), .word_o(romWord));

  i2cMaster u_i2cMaster (
    .clk_i, .rst_ni, .byteStb_i(byteStb), .txByte_i(txByte), .lastByte_i(lastByte),
    .byteDone_o(byteDone), .byteNak_o(byteNak),
    .sda_i, .scl_i, .sdaOe_o, .sclOe_o
  );

endmodule

/* sim/codecI2cModel.sv */
`timescale 1ns/1ps
`include "codec_defines.svh"

module codecI2cModel import codecPkg::*; (
  input  logic clk_i,
  input  logic sda_i,
  input  logic scl_i,
  output logic sdaOe_o,  // High pulls SDA low
  output logic sclOe_o   // High pulls SCL low
);

  int nakPos [`INIT_WORDS] = '{default: -1};       // Byte to NAK once, 0 is the address byte
  int stretchLen [`INIT_WORDS] = '{default: 0};    // SCL hold cycles per word
  logic nakUsed [`INIT_WORDS] = '{default: 1'b0};
  logic [31:0] okQ[$];  // {address byte, word} per completed write
  wordIdx_t failQ[$];   // Word index of each NAKed attempt

  logic sdaPrev = 1'b1;
  logic sclPrev = 1'b1;
  logic sdaPull = 1'b0;
  logic sclPull = 1'b0;
  logic inTxn = 1'b0;
  logic ackPhase = 1'b0;  // Slave owns SDA for the ninth bit
  logic nakd = 1'b0;
  logic [7:0] shiftReg = '0;
  logic [7:0] rxBytes [4];
  int bitCnt = 0;
  int byteCnt = 0;
  int holdCnt = 0;
  int okCnt = 0;
  int curWord;

  assign sdaOe_o = sdaPull;
  assign sclOe_o = sclPull;
  assign curWord = okCnt % `INIT_WORDS;  // Table repeats on restart

  always @(posedge clk_i) begin
    sdaPrev <= sda_i;
    sclPrev <= scl_i;
    if (holdCnt > 0) begin
      holdCnt <= holdCnt - 1;
      if (holdCnt == 1) sclPull <= 1'b0;
    end
    if (scl_i && sclPrev && sdaPrev && !sda_i) begin  // START
      inTxn    <= 1'b1;
      bitCnt   <= 0;
      byteCnt  <= 0;
      ackPhase <= 1'b0;
      nakd     <= 1'b0;
    end else if (inTxn && scl_i && sclPrev && !sdaPrev && sda_i) begin  // STOP
      inTxn <= 1'b0;
      if (nakd) begin
        failQ.push_back(wordIdx_t'(curWord));
      end else if (byteCnt == 4) begin
        okQ.push_back({rxBytes[0], rxBytes[1], rxBytes[2], rxBytes[3]});
        okCnt <= okCnt + 1;
      end
    end else if (inTxn && scl_i && !sclPrev && bitCnt < 8) begin
      shiftReg <= {shiftReg[6:0], sda_i};  // MSB first
      bitCnt   <= bitCnt + 1;
    end else if (inTxn && !scl_i && sclPrev) begin
      if (ackPhase) begin
        sdaPull  <= 1'b0;  // Release after ninth bit
        ackPhase <= 1'b0;
        bitCnt   <= 0;
        byteCnt  <= byteCnt + 1;
      end else if (bitCnt == 8 && byteCnt < 4) begin
        ackPhase         <= 1'b1;
        rxBytes[byteCnt] <= shiftReg;
        if (nakPos[curWord] == byteCnt && !nakUsed[curWord]) begin
          nakd             <= 1'b1;  // Leave SDA high
          nakUsed[curWord] <= 1'b1;
        end else begin
          sdaPull <= 1'b1;
        end
      end
      if (stretchLen[curWord] > 0) begin
        sclPull <= 1'b1;  // Hold SCL past the master's low phase
        holdCnt <= stretchLen[curWord];
      end
    end
  end

endmodule

/* sim/codecCtrl_checker.sv */
`timescale 1ns/1ps

module codecCtrl_checker import codecPkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input logic      sda_i,     // Resolved lines
  input logic      scl_i,
  input logic      busy_i,
  input logic      done_i,
  input logic      byteStb_i,
  input i2cState_e mState_i   // Master FSM state
);

  // Data changes only with SCL low, START and STOP aside
  sdaStable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (scl_i && $past(scl_i) && !(mState_i inside {I2C_START, I2C_STOP}))
      |-> (sda_i == $past(sda_i)))
    else $error("SDA moved while SCL high");

  busyDone: assert property (@(posedge clk_i) disable iff (!rst_ni) !(busy_i && done_i))
    else $error("busy and done both high");

  // A byte is handed over only when the master waits for one
  stbIdle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      byteStb_i |-> (mState_i inside {I2C_IDLE, I2C_NEXT}))
    else $error("byte strobe while master busy");

endmodule

bind audioCodecCtrl codecCtrl_checker u_codecCtrlChecker (
  .clk_i, .rst_ni, .sda_i, .scl_i, .busy_i(busy), .done_i(done), .byteStb_i(byteStb),
  .mState_i(u_i2cMaster.state)
);

/* sim/tb_audioCodecCtrl.sv */
`timescale 1ns/1ps
`include "codec_defines.svh"

module tb_audioCodecCtrl import codecPkg::*; ();

  localparam int DoneTimeout = 100000;  // Status polls before giving up
  localparam logic [6:0] CodecAddr = 7'h3B;  // Write byte 0x76 on the wire

  logic clk = 1'b0;
  logic rstN;
  logic regWe;
  logic regRe;
  logic [`REG_AW-1:0] regAddr;
  logic [`REG_DW-1:0] regWdata;
  logic [`REG_DW-1:0] regRdata;
  logic sdaOe;
  logic sclOe;
  logic sdaOeSlv;
  logic sclOeSlv;
  logic sdaLine;
  logic sclLine;

  initWord_t expTable [`INIT_WORDS];
  wordIdx_t expNak[$];  // Words NAKed in the current run
  logic [31:0] rngState = 32'd6175;
  int okBase;
  int failBase;

  assign sdaLine = ~(sdaOe | sdaOeSlv);  // Wired-AND with pull-up
  assign sclLine = ~(sclOe | sclOeSlv);

  always #4 clk = ~clk;

  audioCodecCtrl u_audioCodecCtrl (
    .clk_i(clk), .rst_ni(rstN), .regWe_i(regWe), .regRe_i(regRe), .regAddr_i(regAddr),
    .regWdata_i(regWdata), .regRdata_o(regRdata), .sda_i(sdaLine), .scl_i(sclLine),
    .sdaOe_o(sdaOe), .sclOe_o(sclOe)
  );

  codecI2cModel u_codecI2cModel (
    .clk_i(clk), .sda_i(sdaLine), .scl_i(sclLine), .sdaOe_o(sdaOeSlv), .sclOe_o(sclOeSlv)
  );

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "run stopped");
  endtask

  task automatic checkWord(input string name, input initWord_t got, input initWord_t exp);
    if (got !== exp)
      failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic checkReg(input string name, input logic [`REG_DW-1:0] got,
                          input logic [`REG_DW-1:0] exp);
    if (got !== exp)
      failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic checkAddr(input string name, input logic [6:0] got, input logic [6:0] exp);
    if (got !== exp)
      failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic checkIdx(input string name, input wordIdx_t got, input wordIdx_t exp);
    if (got !== exp)
      failRun($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Waits 1 to 8 idle cycles and ends 1 ns after an edge
  task automatic idleGap();
    int n;
    rngState = xorshift32(rngState);
    n = 1 + int'(rngState[2:0]);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic busWrite(input regAddr_e addr, input logic [`REG_DW-1:0] data);
    regWe = 1'b1;
    regAddr = addr;
    regWdata = data;
    @(posedge clk);
    #1;
    regWe = 1'b0;
  endtask

  task automatic busRead(input regAddr_e addr, output logic [`REG_DW-1:0] data);
    regRe = 1'b1;
    regAddr = addr;
    @(posedge clk);
    #1;
    regRe = 1'b0;
    data = regRdata;  // Registered on the strobe edge
  endtask

  task automatic waitDone();
    logic [`REG_DW-1:0] st;
    int cnt;
    cnt = 0;
    st = '0;
    while (!st[0]) begin
      if (cnt == DoneTimeout) failRun("timed out waiting for done");
      busRead(REG_STATUS, st);
      cnt++;
    end
  endtask

  // Successes must match the table in order and failures the NAKed words
  task automatic checkRun();
    logic [31:0] rec;
    int nOk;
    int nFail;
    nOk = u_codecI2cModel.okQ.size() - okBase;
    nFail = u_codecI2cModel.failQ.size() - failBase;
    if (nOk != `INIT_WORDS)
      failRun($sformatf("%0d writes recorded instead of %0d", nOk, `INIT_WORDS));
    for (int i = 0; i < `INIT_WORDS; i++) begin
      rec = u_codecI2cModel.okQ[okBase + i];
      checkAddr($sformatf("addr[%0d]", i), rec[31:25], CodecAddr);
      if (rec[24]) failRun($sformatf("write %0d carries the read bit", i));
      checkWord($sformatf("word[%0d]", i), rec[23:0], expTable[i]);
    end
    if (nFail != expNak.size())
      failRun($sformatf("%0d failed attempts instead of %0d", nFail, expNak.size()));
    for (int j = 0; j < nFail; j++)
      checkIdx($sformatf("nakWord[%0d]", j), u_codecI2cModel.failQ[failBase + j], expNak[j]);
    expNak.delete();
  endtask

  initial begin
    int fd;
    int rc;
    int a;
    int b;
    logic [7:0] op;
    logic [1023:0] line;
    initWord_t w;
    regAddr_e ra;
    logic [`REG_DW-1:0] v;
    logic [`REG_DW-1:0] got;
    rstN = 1'b0;
    regWe = 1'b0;
    regRe = 1'b0;
    regAddr = '0;
    regWdata = '0;
    okBase = 0;
    failBase = 0;
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
    checkReg("sdaOe_o", `REG_DW'(sdaOe), '0);
    checkReg("sclOe_o", `REG_DW'(sclOe), '0);
    fd = $fopen("sim/codec_stim.txt", "r");
    if (fd == 0) failRun("cannot open sim/codec_stim.txt");
    while ($fscanf(fd, "%s", op) == 1) begin
      case (op)
        "#": rc = $fgets(line, fd);
        "E": begin
          rc = $fscanf(fd, "%d %d", a, b);  // First index and word count
          for (int k = 0; k < b; k++) begin
            rc = $fscanf(fd, "%h", w);
            expTable[a + k] = w;
          end
        end
        "N": begin
          rc = $fscanf(fd, "%d %d", a, b);  // Word and byte position
          u_codecI2cModel.nakPos[a] = b;
          expNak.push_back(wordIdx_t'(a));
        end
        "T": begin
          rc = $fscanf(fd, "%d %d", a, b);
          u_codecI2cModel.stretchLen[a] = b;
        end
        "S": begin
          okBase = u_codecI2cModel.okQ.size();
          failBase = u_codecI2cModel.failQ.size();
          idleGap();
          busWrite(REG_CTRL, `REG_DW'(1));
        end
        "X": begin
          idleGap();
          busWrite(REG_CTRL, `REG_DW'(1));  // Must be dropped while busy
        end
        "R": begin
          rc = $fscanf(fd, "%d %h", a, v);
          ra = regAddr_e'(a[`REG_AW-1:0]);
          idleGap();
          busRead(ra, got);
          checkReg(ra.name(), got, v);
        end
        "W": begin
          waitDone();
          checkRun();
        end
        default: failRun($sformatf("unknown stim op %s", op));
      endcase
    end
    $fclose(fd);
    $display("All checks passed");
    $finish;
  end

endmodule

/* sim/codec_stim.txt */
# E first count words | N word bytePos (0 = address byte) | T word sclHoldCycles
# S start | X start while busy | R regAddr expectedHex | W wait for done, check writes
E 0 10 400003 401500 401600 401700 40f800 401913 402a03 402903 40f201 40f97f
E 10 10 40fa03 402003 402200 402109 4025e6 4026e6 402700 4023e6 4024e6 400a01
E 20 9 400b05 400c01 400d05 401c21 401d00 401e41 401f00 40f301 40f400
R 1 0
R 2 0
R 3 0
N 3 2
N 17 0
T 5 20
T 20 12
S
R 1 2
X
W
R 1 1
R 2 2
R 3 1c
S
R 1 2
W
R 1 1
R 2 0
R 3 1c

/* filelist.f */
+incdir+common
common/codecPkg.sv
codecInit/codecInitRom.sv
codecInit/codecInitSeq.sv
i2cMaster/i2cMaster.sv
src/codecRegs.sv
src/audioCodecCtrl.sv
sim/codecI2cModel.sv
sim/codecCtrl_checker.sv
sim/tb_audioCodecCtrl.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module tb_audioCodecCtrl
./obj_dir/Vtb_audioCodecCtrl | tee sim.log
if grep -qx "All checks passed" sim.log; then
  exit 0
else
  exit 1
fi
